// File: list.f
+incdir+src
src/fetch_pkg.sv
src/insn_expander.sv
src/fetch_control.sv
src/fetch_slot.sv
src/issue_select.sv
src/fetch_unit.sv
tb/fetch_unit_properties.sv
tb/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module fetch_unit_tb -f list.f
	./obj_dir/Vfetch_unit_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit_tb
	import fetch_pkg::*;
;

	localparam int N_ROWS = 6;
	localparam int MAX_WORDS = 8;
	localparam int MAX_EXP = 6;
	localparam logic [31:0] BASE = `FETCH_RSTPC;

	logic clk;
	logic rst;
	bus_wr_t bus_i;
	logic ack_o;
	logic [2:0] cmpgrp_i;
	insn_t insn_i;
	logic phit_i;
	logic freeze_i;
	logic [1:0] predict_taken_i;
	logic queued_i;
	logic branchmiss_i;
	logic [31:0] misspc_i;
	logic [31:0] pc_o;
	issue_t issue_o;
	logic take_branch_o;
	logic [3:0] panic_o;

	// stimulus table, one row per program run
	string t_name [N_ROWS];
	logic [1:0] t_pred [N_ROWS];
	// issue count after which branchmiss fires, -1 for none
	int t_miss_after [N_ROWS];
	logic [31:0] t_miss_pc [N_ROWS];
	int t_prog_n [N_ROWS];
	logic [31:0] t_prog_pc [N_ROWS][MAX_WORDS];
	insn_t t_prog_word [N_ROWS][MAX_WORDS];
	int t_exp_n [N_ROWS];
	logic [31:0] t_exp_pc [N_ROWS][MAX_EXP];
	insn_t t_exp_instr [N_ROWS][MAX_EXP];
	int n_rows;

	// instruction memory seen by the fetch address
	insn_t imem [logic [31:0]];

	int n_checks;
	int n_mismatch;
	int n_other;
	int run_cycles;
	int cycle_limit;
	bit timed_out;

	fetch_unit DUT (
		.clk(clk),
		.rst(rst),
		.bus_i(bus_i),
		.ack_o(ack_o),
		.cmpgrp_i(cmpgrp_i),
		.insn_i(insn_i),
		.phit_i(phit_i),
		.freeze_i(freeze_i),
		.predict_taken_i(predict_taken_i),
		.queued_i(queued_i),
		.branchmiss_i(branchmiss_i),
		.misspc_i(misspc_i),
		.pc_o(pc_o),
		.issue_o(issue_o),
		.take_branch_o(take_branch_o),
		.panic_o(panic_o)
	);

	bind fetch_control fetch_unit_properties u_props (
		.clk(clk),
		.rst(rst),
		.branchmiss_i(branchmiss_i),
		.queued_i(queued_i),
		.sel_valid_i(sel_valid_i),
		.slot_valid_i(slot_valid_i),
		.ptr_i(ptr_o),
		.panic_i(panic_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// compare tasks
	// ========================================

	task automatic check_issue(input string name, input issue_t want, input issue_t got);
		string want_s;
		string got_s;
		logic bad;
		n_checks++;
		// an invalid issue carries no payload worth comparing
		bad = want.valid ? (want !== got) : (got.valid !== 1'b0);
		if (bad)
		begin
			want_s = $sformatf("valid %b pc %h instr %h len %0d pt %b",
				want.valid, want.pc, want.instr, want.len, want.predict_taken);
			got_s = $sformatf("valid %b pc %h instr %h len %0d pt %b",
				got.valid, got.pc, got.instr, got.len, got.predict_taken);
			$display("Mismatch %s issue: expected %s, actual %s", name, want_s, got_s);
			n_mismatch++;
		end
	endtask

	task automatic check_pc(input string name, input logic [31:0] want, input logic [31:0] got);
		n_checks++;
		if (got !== want)
		begin
			$display("Mismatch %s pc: expected %h, actual %h", name, want, got);
			n_mismatch++;
		end
	endtask

	task automatic check_panic(input string name, input logic [3:0] want, input logic [3:0] got);
		n_checks++;
		if (got !== want)
		begin
			$display("Mismatch %s panic: expected %h, actual %h", name, want, got);
			n_mismatch++;
		end
	endtask

	task automatic check_ack(input string name, input logic want, input logic got);
		n_checks++;
		if (got !== want)
		begin
			$display("Mismatch %s ack: expected %b, actual %b", name, want, got);
			n_mismatch++;
		end
	endtask

	task automatic check_take(input string name, input logic want, input logic got);
		n_checks++;
		if (got !== want)
		begin
			$display("Mismatch %s take: expected %b, actual %b", name, want, got);
			n_mismatch++;
		end
	endtask

	// ========================================
	// table and memory helpers
	// ========================================

	// length from the size code, bit 7 marks a compressed word
	function automatic logic [2:0] len_of(input insn_t w);
		if (w[7])
			return 3'd2;
		else if (w[6])
			return 3'd6;
		return 3'd4;
	endfunction

	// unmapped addresses read as a plain 4 byte nop
	function automatic insn_t fetch_word(input logic [31:0] addr);
		if (imem.exists(addr))
			return imem[addr];
		return 48'h0000_0000_001C;
	endfunction

	task automatic new_row(input string name, input logic [1:0] pred, input int miss_after,
		input logic [31:0] miss_pc);
		t_name[n_rows] = name;
		t_pred[n_rows] = pred;
		t_miss_after[n_rows] = miss_after;
		t_miss_pc[n_rows] = miss_pc;
		t_prog_n[n_rows] = 0;
		t_exp_n[n_rows] = 0;
		n_rows++;
	endtask

	task automatic add_word(input logic [31:0] pc, input insn_t word);
		int r;
		r = n_rows - 1;
		t_prog_pc[r][t_prog_n[r]] = pc;
		t_prog_word[r][t_prog_n[r]] = word;
		t_prog_n[r]++;
	endtask

	task automatic add_expect(input logic [31:0] pc, input insn_t instr);
		int r;
		r = n_rows - 1;
		t_exp_pc[r][t_exp_n[r]] = pc;
		t_exp_instr[r][t_exp_n[r]] = instr;
		t_exp_n[r]++;
		// twenty cycles allowed per expected issue
		cycle_limit += 20;
	endtask

	task automatic build_table();
		// 4 and 6 byte words advance the address by their length
		new_row("sequential", 2'b00, -1, '0);
		add_word(BASE + 32'h00, 48'h0000_A000_001C);
		add_word(BASE + 32'h04, 48'h0000_A004_005C);
		add_word(BASE + 32'h0A, 48'h0000_A00A_001C);
		add_word(BASE + 32'h0E, 48'h0000_A00E_005C);
		add_word(BASE + 32'h14, 48'h0000_A014_001C);
		add_expect(BASE + 32'h00, 48'h0000_A000_001C);
		add_expect(BASE + 32'h04, 48'h0000_A004_005C);
		add_expect(BASE + 32'h0A, 48'h0000_A00A_001C);
		add_expect(BASE + 32'h0E, 48'h0000_A00E_005C);
		add_expect(BASE + 32'h14, 48'h0000_A014_001C);

		// compressed words index the table with group 1
		new_row("compressed", 2'b00, -1, '0);
		add_word(BASE + 32'h00, 48'h0000_0000_059C);
		add_word(BASE + 32'h02, 48'h0000_0000_069C);
		add_word(BASE + 32'h04, 48'h0000_B004_001C);
		add_word(BASE + 32'h08, 48'h0000_0000_079C);
		add_expect(BASE + 32'h00, 48'hC0DE_0105_001C);
		add_expect(BASE + 32'h02, 48'hC0DE_0106_005C);
		add_expect(BASE + 32'h04, 48'h0000_B004_001C);
		add_expect(BASE + 32'h08, 48'hC0DE_0107_001C);

		// jump to FFFC0200, the word after it is never issued
		new_row("jump", 2'b00, -1, '0);
		add_word(BASE + 32'h000, 48'h0000_C000_001C);
		add_word(BASE + 32'h004, 48'h007F_FE01_0028);
		add_word(BASE + 32'h008, 48'h0000_C008_001C);
		add_word(BASE + 32'h100, 48'h0000_C200_005C);
		add_word(BASE + 32'h106, 48'h0000_C206_001C);
		add_expect(BASE + 32'h000, 48'h0000_C000_001C);
		add_expect(BASE + 32'h004, 48'h007F_FE01_0028);
		add_expect(BASE + 32'h100, 48'h0000_C200_005C);
		add_expect(BASE + 32'h106, 48'h0000_C206_001C);

		// branch at +4 with displacement 0x10 halfwords
		new_row("bcc_taken", 2'b11, -1, '0);
		add_word(BASE + 32'h00, 48'h0000_D000_001C);
		add_word(BASE + 32'h04, 48'h0000_0010_0030);
		add_word(BASE + 32'h08, 48'h0000_D008_001C);
		add_word(BASE + 32'h24, 48'h0000_D024_005C);
		add_word(BASE + 32'h2A, 48'h0000_D02A_001C);
		add_expect(BASE + 32'h00, 48'h0000_D000_001C);
		add_expect(BASE + 32'h04, 48'h0000_0010_0030);
		add_expect(BASE + 32'h24, 48'h0000_D024_005C);
		add_expect(BASE + 32'h2A, 48'h0000_D02A_001C);

		// same branch predicted not taken falls through
		new_row("bcc_not_taken", 2'b00, -1, '0);
		add_word(BASE + 32'h00, 48'h0000_E000_001C);
		add_word(BASE + 32'h04, 48'h0000_0010_0030);
		add_word(BASE + 32'h08, 48'h0000_E008_001C);
		add_word(BASE + 32'h0C, 48'h0000_E00C_005C);
		add_expect(BASE + 32'h00, 48'h0000_E000_001C);
		add_expect(BASE + 32'h04, 48'h0000_0010_0030);
		add_expect(BASE + 32'h08, 48'h0000_E008_001C);
		add_expect(BASE + 32'h0C, 48'h0000_E00C_005C);

		// miss after two issues, resume at FFFC0300
		new_row("branch_miss", 2'b00, 2, BASE + 32'h200);
		add_word(BASE + 32'h000, 48'h0000_F000_001C);
		add_word(BASE + 32'h004, 48'h0000_F004_001C);
		add_word(BASE + 32'h008, 48'h0000_F008_001C);
		add_word(BASE + 32'h00C, 48'h0000_F00C_001C);
		add_word(BASE + 32'h200, 48'h0000_F300_005C);
		add_word(BASE + 32'h206, 48'h0000_F306_001C);
		add_expect(BASE + 32'h000, 48'h0000_F000_001C);
		add_expect(BASE + 32'h004, 48'h0000_F004_001C);
		add_expect(BASE + 32'h200, 48'h0000_F300_005C);
		add_expect(BASE + 32'h206, 48'h0000_F306_001C);
	endtask

	// ========================================
	// run sequences
	// ========================================

	// returns at a falling edge with rst released
	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		phit_i = 1'b0;
		queued_i = 1'b0;
		branchmiss_i = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
	endtask

	// one table write, ack expected in the same cycle
	task automatic write_table(input logic [10:0] idx, input insn_t data);
		bus_i.cs = 1'b1;
		bus_i.cyc = 1'b1;
		bus_i.stb = 1'b1;
		bus_i.we = 1'b1;
		bus_i.adr = {2'b00, idx, 3'b000};
		bus_i.dat = data;
		@(posedge clk);
		check_ack("table_write", 1'b1, ack_o);
		@(negedge clk);
		bus_i = '0;
	endtask

	// strobe low, no ack
	task automatic bus_idle();
		bus_i.cs = 1'b1;
		bus_i.cyc = 1'b1;
		bus_i.we = 1'b1;
		@(posedge clk);
		check_ack("bus_idle", 1'b0, ack_o);
		@(negedge clk);
		bus_i = '0;
	endtask

	task automatic run_row(input int r);
		issue_t idle;
		issue_t want;
		issue_t cur;
		logic want_take;
		int got;
		bit miss_done;
		bit miss_pending;
		idle = '0;
		got = 0;
		miss_done = 1'b0;
		miss_pending = 1'b0;
		imem.delete();
		for (int i = 0; i < t_prog_n[r]; i++)
			imem[t_prog_pc[r][i]] = t_prog_word[r][i];
		predict_taken_i = t_pred[r];
		misspc_i = t_miss_pc[r];
		apply_reset();
		check_pc(t_name[r], `FETCH_RSTPC, pc_o);
		check_issue(t_name[r], idle, issue_o);
		check_take(t_name[r], 1'b0, take_branch_o);
		check_panic(t_name[r], `PANIC_NONE, panic_o);

		while (got < t_exp_n[r] && !timed_out)
		begin
			if (run_cycles >= cycle_limit)
			begin
				$display("timeout in %s: issue %0d never arrived, run stopped after %0d cycles",
					t_name[r], got, run_cycles);
				n_other++;
				timed_out = 1'b1;
			end
			else
			begin
				// mid cycle, the issue port is settled
				cur = issue_o;
				branchmiss_i = 1'b0;
				insn_i = fetch_word(pc_o);
				phit_i = ($urandom % 4) != 0;
				// redirect shows on pc one cycle after the miss
				if (miss_pending)
				begin
					check_pc(t_name[r], t_miss_pc[r], pc_o);
					miss_pending = 1'b0;
				end
				if (!miss_done && t_miss_after[r] >= 0 && got == t_miss_after[r])
				begin
					branchmiss_i = 1'b1;
					queued_i = 1'b0;
					miss_done = 1'b1;
					miss_pending = 1'b1;
				end
				else
				begin
					queued_i = cur.valid && (($urandom % 4) != 0);
				end
				if (queued_i)
				begin
					want.valid = 1'b1;
					want.pc = t_exp_pc[r][got];
					want.instr = t_exp_instr[r][got];
					want.len = len_of(fetch_word(want.pc));
					want.predict_taken = (want.instr[5:0] == `OP_BCC) && t_pred[r][0];
					check_issue(t_name[r], want, cur);
					// jumps always redirect, branches only when predicted
					want_take = (want.instr[5:0] == `OP_JMP)
						|| ((want.instr[5:0] == `OP_BCC) && t_pred[r][0]);
					check_take(t_name[r], want_take, take_branch_o);
					got++;
				end
				@(negedge clk);
				run_cycles++;
			end
		end
		queued_i = 1'b0;
		branchmiss_i = 1'b0;
		check_panic(t_name[r], `PANIC_NONE, panic_o);
	endtask

	// queue accept with both slots empty
	task automatic check_bad_queue();
		issue_t idle;
		idle = '0;
		apply_reset();
		check_issue("bad_queue", idle, issue_o);
		queued_i = 1'b1;
		@(negedge clk);
		queued_i = 1'b0;
		check_panic("bad_queue", `PANIC_BADQUEUE, panic_o);
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial
	begin
		rst = 1'b1;
		bus_i = '0;
		cmpgrp_i = 3'd1;
		insn_i = '0;
		phit_i = 1'b0;
		freeze_i = 1'b0;
		predict_taken_i = 2'b00;
		queued_i = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i = '0;
		n_checks = 0;
		n_mismatch = 0;
		n_other = 0;
		run_cycles = 0;
		cycle_limit = 0;
		timed_out = 1'b0;
		n_rows = 0;
		void'($urandom(32'h79e9_4b1e));

		build_table();
		apply_reset();

		// entries 0x105..0x107 for the compressed run
		write_table(11'h105, 48'hC0DE_0105_001C);
		write_table(11'h106, 48'hC0DE_0106_005C);
		write_table(11'h107, 48'hC0DE_0107_001C);
		bus_idle();

		for (int r = 0; r < n_rows && !timed_out; r++)
			run_row(r);
		if (!timed_out)
			check_bad_queue();

		$display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: tb/fetch_unit_properties.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit_properties
(
	input logic clk,
	input logic rst,
	input logic branchmiss_i,
	input logic queued_i,
	input logic sel_valid_i,
	input logic [1:0] slot_valid_i,
	input logic ptr_i,
	input logic [3:0] panic_i
);

	// a branch miss restarts the issue pointer at slot A
	miss_resets_ptr: assert property (@(posedge clk) disable iff (rst)
		branchmiss_i |=> (ptr_i == 1'b0))
		else $error("issue pointer not back at slot A after a branch miss");

	// reset empties both slots
	reset_empties_slots: assert property (@(posedge clk)
		rst |=> (slot_valid_i == 2'b00))
		else $error("a fetch slot is still valid after reset");

	// panic only from a queue accept with nothing selected
	panic_needs_bad_queue: assert property (@(posedge clk) disable iff (rst)
		((panic_i == `PANIC_NONE) && !(queued_i && !sel_valid_i))
		|=> (panic_i == `PANIC_NONE))
		else $error("panic raised without a queue accept on an empty slot");

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit
	import fetch_pkg::*;
(
	input logic clk,
	input logic rst,
	input bus_wr_t bus_i,
	output logic ack_o,
	input logic [2:0] cmpgrp_i,
	input insn_t insn_i,
	input logic phit_i,
	input logic freeze_i,
	input logic [1:0] predict_taken_i,
	input logic queued_i,
	input logic branchmiss_i,
	input logic [`FETCH_AMSB:0] misspc_i,
	output logic [`FETCH_AMSB:0] pc_o,
	output issue_t issue_o,
	output logic take_branch_o,
	output logic [3:0] panic_o
);

	slot_fill_t exp_fill;
	slot_fill_t slot_fill;
	slot_view_t views [2];
	logic [1:0] fill;
	logic [1:0] clr;
	logic ptr;
	logic sel_take;
	logic sel_valid;
	logic [`FETCH_AMSB:0] sel_target;
	logic [1:0] slot_valid;

	insn_expander u_expander (
		.clk(clk),
		.bus_i(bus_i),
		.ack_o(ack_o),
		.cmpgrp_i(cmpgrp_i),
		.insn_i(insn_i),
		.fill_o(exp_fill)
	);

	// tag the expanded word with the address it was fetched from
	always_comb
	begin
		slot_fill = exp_fill;
		slot_fill.pc = pc_o;
	end

	assign slot_valid = {views[1].valid, views[0].valid};

	fetch_control u_control (
		.clk(clk),
		.rst(rst),
		.fill_len_i(exp_fill.len),
		.phit_i(phit_i),
		.freeze_i(freeze_i),
		.queued_i(queued_i),
		.branchmiss_i(branchmiss_i),
		.misspc_i(misspc_i),
		.sel_take_i(sel_take),
		.sel_target_i(sel_target),
		.sel_valid_i(sel_valid),
		.slot_valid_i(slot_valid),
		.fill_o(fill),
		.clr_o(clr),
		.ptr_o(ptr),
		.pc_o(pc_o),
		.panic_o(panic_o)
	);

	// ========================================
	// slots A and B
	// ========================================

	for (genvar g = 0; g < 2; g++)
	begin : g_slot
		fetch_slot u_slot (
			.clk(clk),
			.rst(rst),
			.fill_i(fill[g]),
			.clr_i(clr[g]),
			.data_i(slot_fill),
			.predict_taken_i(predict_taken_i[g]),
			.view_o(views[g])
		);
	end

	issue_select u_select (
		.ptr_i(ptr),
		.view_a_i(views[0]),
		.view_b_i(views[1]),
		.issue_o(issue_o),
		.take_o(sel_take),
		.target_o(sel_target),
		.valid_o(sel_valid)
	);

	assign take_branch_o = sel_take;

endmodule

// File: src/issue_select.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module issue_select
	import fetch_pkg::*;
(
	input logic ptr_i,
	input slot_view_t view_a_i,
	input slot_view_t view_b_i,
	output issue_t issue_o,
	output logic take_o,
	output logic [`FETCH_AMSB:0] target_o,
	output logic valid_o
);

	slot_view_t cur;
	logic cur_bcc;

	// slot at the head of the buffer
	assign cur = ptr_i ? view_b_i : view_a_i;

	assign cur_bcc = (cur.instr[5:0] == `OP_BCC);

	// ========================================
	// issue port
	// ========================================

	assign issue_o.valid = cur.valid;
	assign issue_o.instr = cur.instr;
	assign issue_o.pc = cur.pc;
	assign issue_o.len = cur.len;
	// jumps are always taken and carry no prediction
	assign issue_o.predict_taken = cur.take & cur_bcc;

	// back to fetch control
	assign take_o = cur.take;
	assign target_o = cur.target;
	assign valid_o = cur.valid;

endmodule

// File: src/fetch_slot.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_slot
	import fetch_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fill_i,
	input logic clr_i,
	input slot_fill_t data_i,
	input logic predict_taken_i,
	output slot_view_t view_o
);

	logic valid_q;
	slot_fill_t data_q;

	logic [5:0] opcode;
	logic is_jmp;
	logic is_bcc;
	logic [`FETCH_AMSB:0] jmp_target;
	logic [`FETCH_AMSB:0] bcc_target;

	// valid bit, fill wins over clear
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
		end
		else if (fill_i)
		begin
			valid_q <= 1'b1;
		end
		else if (clr_i)
		begin
			valid_q <= 1'b0;
		end
	end

	// instruction, address and length
	always_ff @(posedge clk)
	begin
		if (fill_i)
		begin
			data_q <= data_i;
		end
	end

	// ========================================
	// branch decode
	// ========================================

	assign opcode = data_q.instr[5:0];
	assign is_jmp = (opcode == `OP_JMP);
	assign is_bcc = (opcode == `OP_BCC);

	// absolute jump, halfword aligned
	assign jmp_target = {data_q.instr[38:8], 1'b0};

	// pc relative, 16 bit signed halfword displacement
	assign bcc_target = data_q.pc
		+ {{15{data_q.instr[31]}}, data_q.instr[31:16], 1'b0};

	assign view_o.valid = valid_q;
	assign view_o.instr = data_q.instr;
	assign view_o.pc = data_q.pc;
	assign view_o.len = data_q.len;
	assign view_o.take = valid_q & (is_jmp | (is_bcc & predict_taken_i));
	assign view_o.target = is_jmp ? jmp_target : bcc_target;

endmodule

// File: src/fetch_control.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_control
(
	input logic clk,
	input logic rst,
	input logic [2:0] fill_len_i,
	input logic phit_i,
	input logic freeze_i,
	input logic queued_i,
	input logic branchmiss_i,
	input logic [`FETCH_AMSB:0] misspc_i,
	input logic sel_take_i,
	input logic [`FETCH_AMSB:0] sel_target_i,
	input logic sel_valid_i,
	input logic [1:0] slot_valid_i,
	output logic [1:0] fill_o,
	output logic [1:0] clr_o,
	output logic ptr_o,
	output logic [`FETCH_AMSB:0] pc_o,
	output logic [3:0] panic_o
);

	// next state
	logic [`FETCH_AMSB:0] pc_n;
	logic ptr_n;
	logic [3:0] panic_n;

	// slot in front of the queue and the one behind it
	logic sel;
	logic oth;

	assign sel = ptr_o;
	assign oth = ~ptr_o;

	// ========================================
	// fill, clear and redirect decisions
	// ========================================

	always_comb
	begin
		fill_o = 2'b00;
		clr_o = 2'b00;
		pc_n = pc_o;
		ptr_n = ptr_o;
		panic_n = panic_o;

		if (branchmiss_i)
		begin
			// everything buffered is down the wrong path
			pc_n = misspc_i;
			clr_o = 2'b11;
			ptr_n = 1'b0;
		end
		else if (sel_take_i)
		begin
			// redirect, the slot behind the branch is stale
			pc_n = sel_target_i;
			clr_o[oth] = 1'b1;
			if (queued_i)
			begin
				clr_o[sel] = 1'b1;
				ptr_n = oth;
			end
		end
		else
		begin
			// drain the selected slot
			if (queued_i)
			begin
				if (sel_valid_i)
				begin
					clr_o[sel] = 1'b1;
					ptr_n = oth;
				end
				else
				begin
					// queue took something that was not there
					panic_n = `PANIC_BADQUEUE;
				end
			end

			// refill, A before B
			if (phit_i)
			begin
				if (!slot_valid_i[0])
				begin
					fill_o = 2'b01;
				end
				else if (!slot_valid_i[1])
				begin
					fill_o = 2'b10;
				end
			end

			if ((fill_o != 2'b00) && !freeze_i)
			begin
				pc_n = pc_o + {29'd0, fill_len_i};
			end

			// empty buffer restarts at slot A
			if (slot_valid_i == 2'b00)
			begin
				ptr_n = 1'b0;
			end
		end
	end

	// ========================================
	// state registers
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc_o <= `FETCH_RSTPC;
			ptr_o <= 1'b0;
			panic_o <= `PANIC_NONE;
		end
		else
		begin
			pc_o <= pc_n;
			ptr_o <= ptr_n;
			panic_o <= panic_n;
		end
	end

endmodule

// File: src/insn_expander.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module insn_expander
	import fetch_pkg::*;
(
	input logic clk,
	input bus_wr_t bus_i,
	output logic ack_o,
	input logic [2:0] cmpgrp_i,
	input insn_t insn_i,
	output slot_fill_t fill_o
);

	// table index width, 11 bits for 2048 entries
	localparam int DCT_AW = $clog2(`DCT_DEPTH);

	// ========================================
	// decompression table
	// ========================================

	insn_t dct [0:`DCT_DEPTH-1];

	logic bus_sel;
	logic [DCT_AW-1:0] wr_idx;
	logic [DCT_AW-1:0] rd_idx;
	logic compressed;

	// bus cycle aimed at this table
	assign bus_sel = bus_i.cs & bus_i.cyc & bus_i.stb;

	// acknowledge in the same cycle, no wait states
	assign ack_o = bus_sel;

	// entries are 8 bytes apart on the bus
	assign wr_idx = bus_i.adr[DCT_AW+2:3];

	always_ff @(posedge clk)
	begin
		if (bus_sel && bus_i.we)
		begin
			dct[wr_idx] <= bus_i.dat;
		end
	end

	// ========================================
	// expansion and length decode
	// ========================================

	// group select plus the compressed payload byte
	assign rd_idx = {cmpgrp_i, insn_i[15:8]};

	always_comb
	begin
		compressed = 1'b0;
		fill_o.len = 3'd2;
		case (insn_i[7:6]) inside
			`SZ_4: fill_o.len = 3'd4;
			`SZ_6: fill_o.len = 3'd6;
			`SZ_2:
			begin
				compressed = 1'b1;
				fill_o.len = 3'd2;
			end
			default: fill_o.len = 3'd2;
		endcase
	end

	// compressed words come back as their full table entry
	assign fill_o.instr = compressed ? dct[rd_idx] : insn_i;

	// the fetch address is not seen here, the top level supplies it
	assign fill_o.pc = '0;

endmodule

// File: src/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

	// full width instruction as it sits in a fetch buffer slot
	typedef logic [47:0] insn_t;

	// expanded word headed for a slot
	typedef struct packed {
		insn_t instr;
		logic [`FETCH_AMSB:0] pc;
		// byte length, 2, 4 or 6
		logic [2:0] len;
	} slot_fill_t;

	// what one slot shows to the issue selector
	typedef struct packed {
		logic valid;
		insn_t instr;
		logic [`FETCH_AMSB:0] pc;
		logic [2:0] len;
		// slot holds a jump or a predicted taken branch
		logic take;
		logic [`FETCH_AMSB:0] target;
	} slot_view_t;

	// one instruction offered to the queue
	typedef struct packed {
		logic valid;
		insn_t instr;
		logic [`FETCH_AMSB:0] pc;
		logic [2:0] len;
		logic predict_taken;
	} issue_t;

	// table write strobes from the bus
	typedef struct packed {
		logic cs;
		logic cyc;
		logic stb;
		logic we;
		logic [15:0] adr;
		logic [47:0] dat;
	} bus_wr_t;

endpackage

// File: src/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ========================================
// fetch address
// ========================================

// top bit of the fetch address
`define FETCH_AMSB 31
// first fetch after reset
`define FETCH_RSTPC 32'hFFFC0100

// ========================================
// opcodes, instruction bits 5..0
// ========================================

`define OP_BCC 6'h30
`define OP_JMP 6'h28
`define OP_NOP 6'h1C

// size code in bits 7..6
`define SZ_4 2'b00
`define SZ_6 2'b01
// compressed, any code with bit 7 set
`define SZ_2 2'b1?

// decompression table entries
`define DCT_DEPTH 2048

// ========================================
// panic codes
// ========================================

`define PANIC_NONE 4'd0
`define PANIC_BADQUEUE 4'd2

`endif
